// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_sdram_core
FLIST     := flist.f
OBJ_DIR   := obj_dir
VFLAGS    := --timing --assert --top-module $(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
+incdir+source
source/sdram_pkg.sv
source/sdram_refresh_timer.sv
source/sdram_row_tracker.sv
source/sdram_ctrl_fsm.sv
source/sdram_cmd_out.sv
source/sdram_read_path.sv
source/sdram_core.sv
test/tb_sdram_mem.sv
test/tb_sdram_core.sv

// ==== source/sdram_cmd_out.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_cmd_out import sdram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  ctrl_state_e state_i,
    input  logic        refresh_precharge_i,
    input  init_step_e  init_step_i,
    input  host_req_t   req_i,
    output sdram_pins_t pins_o,
    output data_t       dout_o,
    output logic        dout_en_o
);

    sdram_pins_t pins_q;
    data_t       dout_q;
    logic        oe_q;

    // --------------------
    // Command, address, bank, mask
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            pins_q <= '{cke: 1'b0, cmd: CMD_NOP, dqm: '0, bank: '0, addr: '0};
            oe_q   <= 1'b0;
        end
        else
        begin
            // NOP unless the state says otherwise; CKE holds
            pins_q.cmd  <= CMD_NOP;
            pins_q.addr <= '0;
            pins_q.bank <= '0;
            pins_q.dqm  <= '0;
            oe_q        <= 1'b0;
            case (state_i)
                ST_INIT:
                begin
                    case (init_step_i)
                        STEP_CKE_ON:
                            pins_q.cke <= 1'b1;
                        STEP_PRECHARGE_ALL:
                        begin
                            pins_q.cmd <= CMD_PRECHARGE;
                            pins_q.addr[`SDRAM_AUTO_PRECHARGE_BIT] <= 1'b1;
                        end
                        STEP_REFRESH:
                            pins_q.cmd <= CMD_REFRESH;
                        STEP_LOAD_MODE:
                        begin
                            pins_q.cmd  <= CMD_LOAD_MODE;
                            pins_q.addr <= `SDRAM_MODE_VALUE;
                        end
                        default:
                            pins_q.cmd <= CMD_NOP;
                    endcase
                end
                ST_ACTIVATE:
                begin
                    pins_q.cmd  <= CMD_ACTIVE;
                    pins_q.addr <= req_row(req_i.addr);
                    pins_q.bank <= req_bank(req_i.addr);
                end
                ST_PRECHARGE:
                begin
                    pins_q.cmd <= CMD_PRECHARGE;
                    // All banks ahead of a refresh, else just this one
                    if (refresh_precharge_i)
                        pins_q.addr[`SDRAM_AUTO_PRECHARGE_BIT] <= 1'b1;
                    else
                        pins_q.bank <= req_bank(req_i.addr);
                end
                ST_REFRESH:
                    pins_q.cmd <= CMD_REFRESH;
                ST_READ, ST_WRITE:
                begin
                    pins_q.cmd  <= (state_i == ST_READ) ? CMD_READ : CMD_WRITE;
                    pins_q.addr <= addr_t'(req_col(req_i.addr));
                    pins_q.bank <= req_bank(req_i.addr);
                    // Row stays open after the access
                    pins_q.addr[`SDRAM_AUTO_PRECHARGE_BIT] <= 1'b0;
                    if (state_i == ST_WRITE)
                    begin
                        // DQM high masks a byte
                        pins_q.dqm <= ~req_i.wr;
                        oe_q       <= 1'b1;
                    end
                end
                default:
                    pins_q.cmd <= CMD_NOP;
            endcase
        end
    end

    // Write data
    always_ff @(posedge clk_i)
    begin
        if (state_i == ST_WRITE)
            dout_q <= req_i.wdata;
    end

    assign pins_o    = pins_q;
    assign dout_o    = dout_q;
    assign dout_en_o = oe_q;

endmodule

// ==== source/sdram_consts.svh ====
`ifndef SDRAM_CONSTS_SVH
`define SDRAM_CONSTS_SVH

// --------------------
// Geometry
// --------------------
`define SDRAM_DW                 32
`define SDRAM_ROW_W              13
`define SDRAM_BANK_W             2
`define SDRAM_COL_W              9

// --------------------
// Clock and timing
// --------------------
`define SDRAM_MHZ                50
// CAS latency in clocks
`define SDRAM_READ_LATENCY       2
// 100 us of power-up wait
`define SDRAM_START_DELAY        5000
`define SDRAM_REFRESH_CYCLES     389
// Extra wait after ACTIVATE, PRECHARGE and REFRESH
`define SDRAM_TRCD_CYCLES        1
`define SDRAM_TRP_CYCLES         1
`define SDRAM_TRFC_CYCLES        3

// Countdown values of the power-up steps
`define SDRAM_INIT_CKE           50
`define SDRAM_INIT_PRECHARGE     40
`define SDRAM_INIT_REFRESH_A     30
`define SDRAM_INIT_REFRESH_B     20
`define SDRAM_INIT_MODE          10

// A10 selects auto precharge on access, all banks on PRECHARGE
`define SDRAM_AUTO_PRECHARGE_BIT 10
// Burst of one, sequential, CAS 2
`define SDRAM_MODE_VALUE         13'b000_0_00_010_0_000

`endif

// ==== source/sdram_core.sv ====
`timescale 1ns/100ps

module sdram_core import sdram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    // Host port
    input  host_req_t   req_i,
    output logic        accept_o,
    output logic        ack_o,
    output data_t       rdata_o,
    // Device pins
    output sdram_pins_t pins_o,
    output logic        sdram_clk_o,
    input  data_t       din_i,
    output data_t       dout_o,
    output logic        dout_en_o
);

    logic        refresh_pending;
    logic        refresh_done;
    init_step_e  init_step;
    logic        row_hit;
    logic        bank_open;
    logic        any_open;
    ctrl_state_e state;
    logic        refresh_precharge;
    logic        open_bank;
    logic        close_bank;
    logic        close_all;
    logic        rd_issue;
    logic        wr_issue;

    // Device samples mid-cycle
    assign sdram_clk_o = ~clk_i;

    sdram_refresh_timer u_refresh_timer (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .refresh_done_i    (refresh_done),
        .refresh_pending_o (refresh_pending),
        .init_step_o       (init_step)
    );

    sdram_row_tracker u_row_tracker (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .bank_i       (req_bank(req_i.addr)),
        .row_i        (req_row(req_i.addr)),
        .open_bank_i  (open_bank),
        .close_bank_i (close_bank),
        .close_all_i  (close_all),
        .row_hit_o    (row_hit),
        .bank_open_o  (bank_open),
        .any_open_o   (any_open)
    );

    sdram_ctrl_fsm u_ctrl_fsm (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .req_i               (req_i),
        .refresh_pending_i   (refresh_pending),
        .row_hit_i           (row_hit),
        .bank_open_i         (bank_open),
        .any_open_i          (any_open),
        .state_o             (state),
        .refresh_precharge_o (refresh_precharge),
        .open_bank_o         (open_bank),
        .close_bank_o        (close_bank),
        .close_all_o         (close_all),
        .refresh_done_o      (refresh_done),
        .rd_issue_o          (rd_issue),
        .wr_issue_o          (wr_issue),
        .accept_o            (accept_o)
    );

    sdram_cmd_out u_cmd_out (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .state_i             (state),
        .refresh_precharge_i (refresh_precharge),
        .init_step_i         (init_step),
        .req_i               (req_i),
        .pins_o              (pins_o),
        .dout_o              (dout_o),
        .dout_en_o           (dout_en_o)
    );

    sdram_read_path u_read_path (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .din_i      (din_i),
        .rd_issue_i (rd_issue),
        .wr_issue_i (wr_issue),
        .rdata_o    (rdata_o),
        .ack_o      (ack_o)
    );

endmodule

// ==== source/sdram_ctrl_fsm.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_ctrl_fsm import sdram_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_i,
    input  host_req_t   req_i,
    input  logic        refresh_pending_i,
    input  logic        row_hit_i,
    input  logic        bank_open_i,
    input  logic        any_open_i,
    output ctrl_state_e state_o,
    output logic        refresh_precharge_o,
    output logic        open_bank_o,
    output logic        close_bank_o,
    output logic        close_all_o,
    output logic        refresh_done_o,
    output logic        rd_issue_o,
    output logic        wr_issue_o,
    output logic        accept_o
);

    ctrl_state_e state_q;
    ctrl_state_e next_state;
    // Where ACTIVATE or PRECHARGE lead afterwards
    ctrl_state_e target_q;
    ctrl_state_e target_n;
    // Where DELAY returns to
    ctrl_state_e return_q;
    delay_t      delay_q;
    delay_t      delay_n;
    logic        req_rd;
    logic        req_wr;

    assign req_rd = req_i.rd;
    assign req_wr = |req_i.wr;

    // --------------------
    // Issue and accept
    // --------------------
    // Access slot only fires on a hit of its own kind
    assign rd_issue_o = (state_q == ST_READ) && req_rd && row_hit_i;
    assign wr_issue_o = (state_q == ST_WRITE) && req_wr && row_hit_i;
    assign accept_o   = rd_issue_o | wr_issue_o;

    // Empty access slot puts a NOP on the pins
    assign state_o = ((state_q == ST_READ && !rd_issue_o) ||
                      (state_q == ST_WRITE && !wr_issue_o)) ? ST_IDLE : state_q;

    assign refresh_precharge_o = (state_q == ST_PRECHARGE) && (target_q == ST_REFRESH);
    assign close_all_o         = refresh_precharge_o;
    assign close_bank_o        = (state_q == ST_PRECHARGE) && (target_q != ST_REFRESH);
    assign open_bank_o         = (state_q == ST_ACTIVATE);
    assign refresh_done_o      = (state_q == ST_REFRESH);

    // --------------------
    // Next state
    // --------------------
    always_comb
    begin
        next_state = state_q;
        target_n   = target_q;
        delay_n    = '0;
        case (state_q)
            ST_INIT:
            begin
                // First tick of the timer closes power-up
                if (refresh_pending_i)
                    next_state = ST_IDLE;
            end
            ST_IDLE:
            begin
                if (refresh_pending_i)
                begin
                    next_state = any_open_i ? ST_PRECHARGE : ST_REFRESH;
                    target_n   = ST_REFRESH;
                end
                else if (req_rd || req_wr)
                begin
                    target_n = req_rd ? ST_READ : ST_WRITE;
                    if (row_hit_i)
                        next_state = target_n;
                    else if (bank_open_i)
                        next_state = ST_PRECHARGE;
                    else
                        next_state = ST_ACTIVATE;
                end
            end
            ST_ACTIVATE:
            begin
                next_state = target_q;
                delay_n    = delay_t'(`SDRAM_TRCD_CYCLES);
            end
            ST_READ:
            begin
                // Stream on, or let the last read drain before going idle
                if (rd_issue_o && !refresh_pending_i)
                    next_state = ST_READ;
                else
                begin
                    next_state = ST_IDLE;
                    delay_n    = delay_t'(`SDRAM_READ_LATENCY);
                end
            end
            ST_WRITE:
            begin
                if (wr_issue_o && !refresh_pending_i)
                    next_state = ST_WRITE;
                else
                    next_state = ST_IDLE;
            end
            ST_PRECHARGE:
            begin
                next_state = (target_q == ST_REFRESH) ? ST_REFRESH : ST_ACTIVATE;
                delay_n    = delay_t'(`SDRAM_TRP_CYCLES);
            end
            ST_REFRESH:
            begin
                next_state = ST_IDLE;
                delay_n    = delay_t'(`SDRAM_TRFC_CYCLES);
            end
            ST_DELAY:
            begin
                next_state = return_q;
                delay_n    = delay_q - 1'b1;
            end
            default:
                next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            state_q  <= ST_INIT;
            target_q <= ST_IDLE;
            return_q <= ST_IDLE;
            delay_q  <= '0;
        end
        else
        begin
            state_q  <= (delay_n != '0) ? ST_DELAY : next_state;
            target_q <= target_n;
            delay_q  <= delay_n;
            // Latch the way back on entry to DELAY
            if (state_q != ST_DELAY && delay_n != '0)
                return_q <= next_state;
        end
    end

    // Host never mixes a read with a write
    a_req_one_kind: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !(req_i.rd && (|req_i.wr))
    );

endmodule

// ==== source/sdram_pkg.sv ====
`include "sdram_consts.svh"

package sdram_pkg;

    typedef logic [`SDRAM_DW-1:0]     data_t;
    typedef logic [`SDRAM_DW/8-1:0]   strb_t;
    typedef logic [`SDRAM_ROW_W-1:0]  row_t;
    typedef logic [`SDRAM_BANK_W-1:0] bank_t;
    typedef logic [`SDRAM_COL_W-1:0]  col_t;
    // Pin address, shared by row, column and mode
    typedef logic [`SDRAM_ROW_W-1:0]  addr_t;
    typedef logic [3:0]               delay_t;
    typedef logic [16:0]              refresh_cnt_t;

    // {cs_n, ras_n, cas_n, we_n}
    typedef enum logic [3:0] {
        CMD_NOP       = 4'b0111,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_WRITE     = 4'b0100,
        CMD_PRECHARGE = 4'b0010,
        CMD_REFRESH   = 4'b0001,
        CMD_LOAD_MODE = 4'b0000
    } sdram_cmd_e;

    typedef enum logic [2:0] {
        ST_INIT,
        ST_DELAY,
        ST_IDLE,
        ST_ACTIVATE,
        ST_READ,
        ST_WRITE,
        ST_PRECHARGE,
        ST_REFRESH
    } ctrl_state_e;

    typedef enum logic [2:0] {
        STEP_NONE,
        STEP_CKE_ON,
        STEP_PRECHARGE_ALL,
        STEP_REFRESH,
        STEP_LOAD_MODE
    } init_step_e;

    // Host request held until accept
    typedef struct packed {
        strb_t       wr;
        logic        rd;
        logic [31:0] addr;
        data_t       wdata;
    } host_req_t;

    typedef struct packed {
        logic       cke;
        sdram_cmd_e cmd;
        strb_t      dqm;
        bank_t      bank;
        addr_t      addr;
    } sdram_pins_t;

    // Byte address layout, low to high: byte, column, bank, row
    localparam int COL_LSB  = $clog2(`SDRAM_DW / 8);
    localparam int BANK_LSB = COL_LSB + `SDRAM_COL_W;
    localparam int ROW_LSB  = BANK_LSB + `SDRAM_BANK_W;

    function automatic col_t req_col(input logic [31:0] addr);
        return addr[COL_LSB +: `SDRAM_COL_W];
    endfunction

    function automatic bank_t req_bank(input logic [31:0] addr);
        return addr[BANK_LSB +: `SDRAM_BANK_W];
    endfunction

    function automatic row_t req_row(input logic [31:0] addr);
        return addr[ROW_LSB +: `SDRAM_ROW_W];
    endfunction

endpackage

// ==== source/sdram_read_path.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_read_path import sdram_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  data_t din_i,
    input  logic  rd_issue_i,
    input  logic  wr_issue_i,
    output data_t rdata_o,
    output logic  ack_o
);

    // One cycle to the pins, CAS latency, two sampling stages
    localparam int RD_PIPE = `SDRAM_READ_LATENCY + 2;

    data_t              din_p1_q;
    data_t              din_p2_q;
    data_t              rdata_q;
    logic [RD_PIPE-1:0] rd_pipe_q;
    logic               ack_q;

    // --------------------
    // Input sampling
    // --------------------
    always_ff @(posedge clk_i)
    begin
        din_p1_q <= din_i;
        din_p2_q <= din_p1_q;
    end

    // Read events, lined up with the second sample
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_pipe_q <= '0;
            ack_q     <= 1'b0;
        end
        else
        begin
            rd_pipe_q <= {rd_pipe_q[RD_PIPE-2:0], rd_issue_i};
            // Writes ack right away
            ack_q     <= wr_issue_i | rd_pipe_q[RD_PIPE-1];
        end
    end

    // Holds until the next read lands
    always_ff @(posedge clk_i)
    begin
        if (rd_pipe_q[RD_PIPE-1])
            rdata_q <= din_p2_q;
    end

    assign rdata_o = rdata_q;
    assign ack_o   = ack_q;

endmodule

// ==== source/sdram_refresh_timer.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_refresh_timer import sdram_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_i,
    input  logic       refresh_done_i,
    output logic       refresh_pending_o,
    output init_step_e init_step_o
);

    refresh_cnt_t cnt_q;
    logic         cnt_zero;
    logic         init_done_q;

    assign cnt_zero = (cnt_q == '0);

    // --------------------
    // Countdown
    // --------------------
    // First expiry ends the power-up wait, later ones are refresh ticks
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            cnt_q       <= refresh_cnt_t'(`SDRAM_START_DELAY + 100);
            init_done_q <= 1'b0;
        end
        else
        begin
            if (cnt_zero)
                cnt_q <= refresh_cnt_t'(`SDRAM_REFRESH_CYCLES);
            else
                cnt_q <= cnt_q - 1'b1;
            if (cnt_zero)
                init_done_q <= 1'b1;
        end
    end

    // Set wins over the clear of a refresh in the same cycle
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            refresh_pending_o <= 1'b0;
        else if (cnt_zero)
            refresh_pending_o <= 1'b1;
        else if (refresh_done_i)
            refresh_pending_o <= 1'b0;
    end

    // --------------------
    // Power-up steps
    // --------------------
    always_comb
    begin
        init_step_o = STEP_NONE;
        // Only on the first pass of the countdown
        if (!init_done_q)
        begin
            case (cnt_q)
                refresh_cnt_t'(`SDRAM_INIT_CKE):       init_step_o = STEP_CKE_ON;
                refresh_cnt_t'(`SDRAM_INIT_PRECHARGE): init_step_o = STEP_PRECHARGE_ALL;
                refresh_cnt_t'(`SDRAM_INIT_REFRESH_A): init_step_o = STEP_REFRESH;
                refresh_cnt_t'(`SDRAM_INIT_REFRESH_B): init_step_o = STEP_REFRESH;
                refresh_cnt_t'(`SDRAM_INIT_MODE):      init_step_o = STEP_LOAD_MODE;
                default:                               init_step_o = STEP_NONE;
            endcase
        end
    end

    // FSM only refreshes on request
    a_refresh_needs_pending: assert property (
        @(posedge clk_i) disable iff (rst_i)
        refresh_done_i |-> refresh_pending_o
    );

endmodule

// ==== source/sdram_row_tracker.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module sdram_row_tracker import sdram_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  bank_t bank_i,
    input  row_t  row_i,
    input  logic  open_bank_i,
    input  logic  close_bank_i,
    input  logic  close_all_i,
    output logic  row_hit_o,
    output logic  bank_open_o,
    output logic  any_open_o
);

    localparam int NUM_BANKS = 1 << `SDRAM_BANK_W;

    logic [NUM_BANKS-1:0] open_q;
    // Open row per bank, valid while its flag is set
    row_t                 rows_q [NUM_BANKS];

    // --------------------
    // Open flags
    // --------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            open_q <= '0;
        else if (close_all_i)
            open_q <= '0;
        else if (open_bank_i)
            open_q[bank_i] <= 1'b1;
        else if (close_bank_i)
            open_q[bank_i] <= 1'b0;
    end

    // Row table
    always_ff @(posedge clk_i)
    begin
        if (open_bank_i)
            rows_q[bank_i] <= row_i;
    end

    // Lookup for the requested bank
    assign bank_open_o = open_q[bank_i];
    assign row_hit_o   = open_q[bank_i] && (rows_q[bank_i] == row_i);
    // Refresh needs all rows closed first
    assign any_open_o  = |open_q;

    // Activate only reaches a precharged bank
    a_open_closed_bank: assert property (
        @(posedge clk_i) disable iff (rst_i)
        open_bank_i |-> !open_q[bank_i]
    );

endmodule

// ==== test/tb_sdram_core.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module tb_sdram_core import sdram_pkg::*;
();

    localparam int NUM_REQS        = 300;
    localparam int TIMEOUT_CYCLES  = `SDRAM_START_DELAY + NUM_REQS * 20 + 1000;
    localparam int READ_ACK_DELAY  = `SDRAM_READ_LATENCY + 3;
    localparam int REFRESH_GAP_MAX = `SDRAM_REFRESH_CYCLES + 20;

    logic        clk_i;
    logic        rst_i;
    host_req_t   req;
    logic        accept;
    logic        ack;
    data_t       rdata;
    sdram_pins_t pins;
    logic        sdram_clk;
    data_t       din;
    data_t       dout;
    logic        dout_en;
    logic        mem_err;

    int          cyc;
    // Expected acknowledges in time order
    int          ack_time_q [$];
    logic        ack_rd_q [$];
    data_t       ack_data_q [$];
    data_t       ref_mem [int];

    logic        cke_seen;
    logic        first_accept;
    int          init_idx;
    int          since_refresh;
    sdram_cmd_e  init_cmds [4];
    logic        ack_exp;

    sdram_core u_dut (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .req_i       (req),
        .accept_o    (accept),
        .ack_o       (ack),
        .rdata_o     (rdata),
        .pins_o      (pins),
        .sdram_clk_o (sdram_clk),
        .din_i       (din),
        .dout_o      (dout),
        .dout_en_o   (dout_en)
    );

    tb_sdram_mem u_mem (
        .sdram_clk_i (sdram_clk),
        .pins_i      (pins),
        .dout_i      (dout),
        .dout_en_i   (dout_en),
        .din_o       (din),
        .err_o       (mem_err)
    );

    always #4 clk_i = ~clk_i;

    // --------------------
    // Compare and stop
    // --------------------
    task automatic abort_run(input string what);
        $display("%0t: %s", $time, what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
            abort_run("data mismatch");
        end
    endtask

    task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %s expected %s", $time, name, got.name(), exp.name());
            abort_run("command mismatch");
        end
    endtask

    task automatic check_ack(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
            abort_run("control mismatch");
        end
    endtask

    // Same spread as the device model over the word address
    function automatic data_t fill_word(input logic [23:0] word_idx);
        return {word_idx[7:0], word_idx} ^ 32'h5a3c_96e1;
    endfunction

    always @(posedge clk_i)
    begin
        cyc <= cyc + 1;
        if (cyc > TIMEOUT_CYCLES)
            abort_run("timeout, requests did not complete");
        if (mem_err)
            abort_run("device model saw a protocol violation");
    end

    // --------------------
    // Reset, power-up and refresh spacing
    // --------------------
    always @(negedge clk_i)
    begin
        if (rst_i)
        begin
            check_ack("pins.cke", pins.cke, 1'b0);
            check_cmd("pins.cmd", pins.cmd, CMD_NOP);
            check_ack("ack_o", ack, 1'b0);
            check_ack("accept_o", accept, 1'b0);
        end
        else if (!first_accept)
        begin
            if (!cke_seen)
            begin
                check_cmd("pins.cmd", pins.cmd, CMD_NOP);
                check_ack("accept_o", accept, 1'b0);
                cke_seen = pins.cke;
            end
            else if (init_idx < 4 && pins.cmd != CMD_NOP)
            begin
                check_cmd("pins.cmd", pins.cmd, init_cmds[init_idx]);
                if (init_idx == 0)
                    check_ack("pins.addr[10]", pins.addr[`SDRAM_AUTO_PRECHARGE_BIT], 1'b1);
                if (init_idx == 3)
                    check_data("pins.addr", data_t'(pins.addr), data_t'(`SDRAM_MODE_VALUE));
                init_idx = init_idx + 1;
            end
            if (accept)
            begin
                if (init_idx != 4)
                    abort_run("request accepted before power-up finished");
                first_accept = 1'b1;
            end
        end
        // Refresh spacing once the mode is loaded
        if (init_idx == 4)
        begin
            if (pins.cmd == CMD_REFRESH)
                since_refresh = 0;
            else
                since_refresh = since_refresh + 1;
            if (since_refresh > REFRESH_GAP_MAX)
                abort_run("refresh interval too long");
        end
    end

    // Acknowledge timing and read data
    always @(negedge clk_i)
    begin
        if (!rst_i)
        begin
            ack_exp = (ack_time_q.size() > 0) && (ack_time_q[0] == cyc);
            check_ack("ack_o", ack, ack_exp);
            if (ack_exp)
            begin
                if (ack_rd_q[0])
                    check_data("rdata_o", rdata, ack_data_q[0]);
                void'(ack_time_q.pop_front());
                void'(ack_rd_q.pop_front());
                void'(ack_data_q.pop_front());
            end
        end
    end

    // --------------------
    // Host traffic
    // --------------------
    task automatic do_request(input logic [31:0] addr, input logic rd, input strb_t strb,
                              input data_t wdata);
        logic  accepted;
        int    key;
        data_t word;
        accepted  = 1'b0;
        @(posedge clk_i);
        #1;
        req.rd    = rd;
        req.wr    = strb;
        req.addr  = addr;
        req.wdata = wdata;
        while (!accepted)
        begin
            @(negedge clk_i);
            accepted = accept;
        end
        key  = int'(addr[25:2]);
        word = ref_mem.exists(key) ? ref_mem[key] : fill_word(addr[25:2]);
        if (!rd)
            for (int i = 0; i < `SDRAM_DW / 8; i++)
                if (strb[i])
                    word[8*i +: 8] = wdata[8*i +: 8];
        ref_mem[key] = word;
        ack_time_q.push_back(cyc + (rd ? READ_ACK_DELAY : 1));
        ack_rd_q.push_back(rd);
        ack_data_q.push_back(word);
    endtask

    initial
    begin
        logic [31:0] addr;
        row_t        row;
        int          gap;
        init_cmds[0]  = CMD_PRECHARGE;
        init_cmds[1]  = CMD_REFRESH;
        init_cmds[2]  = CMD_REFRESH;
        init_cmds[3]  = CMD_LOAD_MODE;
        clk_i         = 1'b0;
        rst_i         = 1'b1;
        req           = '0;
        cyc           = 0;
        cke_seen      = 1'b0;
        first_accept  = 1'b0;
        init_idx      = 0;
        since_refresh = 0;
        void'($urandom(32'ha3dd_1c8d));
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        for (int n = 0; n < NUM_REQS; n++)
        begin
            // Two rows per bank and a few columns
            row  = ($urandom % 2) ? 13'h0a5 : 13'h1c3;
            addr = '0;
            addr[ROW_LSB +: `SDRAM_ROW_W]   = row;
            addr[BANK_LSB +: `SDRAM_BANK_W] = bank_t'($urandom % 4);
            addr[COL_LSB +: `SDRAM_COL_W]   = col_t'($urandom % 4);
            if ($urandom % 2)
                do_request(addr, 1'b1, '0, '0);
            else
                do_request(addr, 1'b0, strb_t'($urandom % 15 + 1), $urandom);
            gap = ($urandom % 4 == 0) ? int'($urandom % 6) : 0;
            if (gap > 0)
            begin
                @(posedge clk_i);
                #1;
                req = '0;
                repeat (gap - 1) @(posedge clk_i);
            end
        end
        @(posedge clk_i);
        #1;
        req = '0;
        while (ack_time_q.size() > 0)
            @(posedge clk_i);
        // Idle tail, no stray acknowledge may follow
        repeat (10) @(posedge clk_i);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== test/tb_sdram_mem.sv ====
`timescale 1ns/100ps
`include "sdram_consts.svh"

module tb_sdram_mem import sdram_pkg::*;
(
    input  logic        sdram_clk_i,
    input  sdram_pins_t pins_i,
    input  data_t       dout_i,
    input  logic        dout_en_i,
    output data_t       din_o,
    output logic        err_o
);

    localparam int NUM_BANKS = 1 << `SDRAM_BANK_W;

    // Word store keyed by {row, bank, column}
    data_t                mem [int];
    logic [NUM_BANKS-1:0] open_q;
    row_t                 rows_q [NUM_BANKS];
    int                   act_cyc [NUM_BANKS];
    int                   cyc;
    logic                 rd_pend;
    data_t                rd_word;
    int                   idx;
    bank_t                bnk;

    // Unwritten words, spread over the whole index
    function automatic data_t fill_word(input logic [23:0] word_idx);
        return {word_idx[7:0], word_idx} ^ 32'h5a3c_96e1;
    endfunction

    task automatic protocol_error(input string what);
        $display("device model at %0t: %s", $time, what);
        err_o = 1'b1;
    endtask

    initial
    begin
        open_q  = '0;
        cyc     = 0;
        rd_pend = 1'b0;
        rd_word = '0;
        din_o   = '0;
        err_o   = 1'b0;
    end

    // --------------------
    // Command decode
    // --------------------
    // Rising edge of the device clock, mid-cycle of the core clock
    always @(posedge sdram_clk_i)
    begin
        cyc = cyc + 1;
        // Word of the previous READ, one cycle later for CAS 2
        if (rd_pend)
        begin
            din_o   = rd_word;
            rd_pend = 1'b0;
        end
        bnk = pins_i.bank;
        case (pins_i.cmd)
            CMD_ACTIVE:
            begin
                if (open_q[bnk])
                    protocol_error("ACTIVE to a bank that is already open");
                open_q[bnk]  = 1'b1;
                rows_q[bnk]  = pins_i.addr;
                act_cyc[bnk] = cyc;
            end
            CMD_READ, CMD_WRITE:
            begin
                if (!open_q[bnk])
                    protocol_error("access to a closed bank");
                if (pins_i.addr[`SDRAM_AUTO_PRECHARGE_BIT])
                    protocol_error("access with auto precharge set");
                if (cyc - act_cyc[bnk] <= `SDRAM_TRCD_CYCLES)
                    protocol_error("access too soon after ACTIVE");
                idx = int'({rows_q[bnk], bnk, pins_i.addr[`SDRAM_COL_W-1:0]});
                if (pins_i.cmd == CMD_READ)
                begin
                    rd_word = mem.exists(idx) ? mem[idx] : fill_word(idx[23:0]);
                    rd_pend = 1'b1;
                end
                else
                begin
                    if (!dout_en_i)
                        protocol_error("WRITE without output enable");
                    if (!mem.exists(idx))
                        mem[idx] = fill_word(idx[23:0]);
                    // DQM high keeps the old byte
                    for (int i = 0; i < `SDRAM_DW / 8; i++)
                        if (!pins_i.dqm[i])
                            mem[idx][8*i +: 8] = dout_i[8*i +: 8];
                end
            end
            CMD_PRECHARGE:
            begin
                if (pins_i.addr[`SDRAM_AUTO_PRECHARGE_BIT])
                    open_q = '0;
                else
                    open_q[bnk] = 1'b0;
            end
            CMD_REFRESH:
            begin
                if (|open_q)
                    protocol_error("REFRESH with a row still open");
            end
            default:
            begin
            end
        endcase
    end

endmodule
